// ==== hdl/csr_bridge.sv ====
// Wishbone to CSR bridge
`timescale 1ns/1ps

module csr_bridge (
	input  logic                          sys_clk,
	input  logic                          sys_rst_i,
	input  wb_pkg::wb_m2s_t               wb_i,
	output wb_pkg::wb_s2m_t               wb_o,
	output csr_pkg::csr_m2s_t             csr_o,
	input  logic [csr_pkg::CSR_DAT_W-1:0] csr_dr_i
);
	import wb_pkg::*;
	import csr_pkg::*;

	logic                issue;
	logic                busy;
	logic                ack;
	logic [WB_DAT_W-1:0] rd_dat;

	// New CSR cycle only when nothing is in flight
	assign issue = wb_i.cyc & wb_i.stb & ~busy & ~ack;

	// Word address, we pulses for the single issue cycle
	always_comb begin
		csr_o.a = wb_i.adr[CSR_ADR_W+1:2];
		csr_o.we = issue & wb_i.we;
		csr_o.dw = wb_i.dat;
	end

	// ----------------------------------------
	// Issue, then capture and ack
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			busy <= 1'b0;
			ack <= 1'b0;
		end else begin
			busy <= issue;
			ack <= busy;
		end
	end

	// Slave read data is valid the cycle after issue
	always_ff @(posedge sys_clk) begin
		if (busy)
			rd_dat <= csr_dr_i;
	end

	assign wb_o.dat = rd_dat;
	assign wb_o.ack = ack;

endmodule

// ==== hdl/csr_pkg.sv ====
// CSR bus and system controller map
package csr_pkg;

	// ----------------------------------------
	// CSR bus
	// ----------------------------------------
	localparam int CSR_ADR_W = 14;
	localparam int CSR_DAT_W = 32;
	localparam int CSR_BANK_W = 4;
	localparam int CSR_REG_W = CSR_ADR_W - CSR_BANK_W;

	// One access per cycle, a taken from Wishbone adr[15:2]
	typedef struct packed {
		logic [CSR_ADR_W-1:0] a;
		logic                 we;
		logic [CSR_DAT_W-1:0] dw;
	} csr_m2s_t;

	// Bank in a[13:10], register in a[9:0]
	localparam logic [CSR_BANK_W-1:0] SYSCTL_BANK = 4'd1;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_IN = 10'd0;
	localparam logic [CSR_REG_W-1:0] REG_GPIO_OUT = 10'd1;
	localparam logic [CSR_REG_W-1:0] REG_TIMER_CTRL = 10'd2;
	localparam logic [CSR_REG_W-1:0] REG_TIMER_CMP = 10'd3;
	localparam logic [CSR_REG_W-1:0] REG_TIMER_CNT = 10'd4;
	localparam logic [CSR_REG_W-1:0] REG_SYSTEM_ID = 10'd5;

	// "SOC1"
	localparam logic [CSR_DAT_W-1:0] SYSTEM_ID = 32'h534F_4331;
	localparam int NUM_GPIO_IN = 3;
	localparam int NUM_GPIO_OUT = 2;

	// Reset sequencing, in sys_clk cycles
	localparam int FLASH_RST_CYCLES = 64;
	localparam int SYS_RST_CYCLES = 128;

endpackage

// ==== hdl/norflash16.sv ====
// 16-bit NOR flash reader
`timescale 1ns/1ps

module norflash16 (
	input  logic                           sys_clk,
	input  logic                           sys_rst_i,
	input  wb_pkg::wb_m2s_t                wb_i,
	output wb_pkg::wb_s2m_t                wb_o,
	output logic [wb_pkg::FLASH_ADR_W-1:0] flash_adr_o,
	input  logic [wb_pkg::FLASH_DAT_W-1:0] flash_d_i
);
	import wb_pkg::*;

	localparam int WAIT_W = $clog2(FLASH_WAIT + 1);
	localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(FLASH_WAIT);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_HIGH,
		ST_LOW
	} state_t;

	state_t              state;
	logic [WAIT_W-1:0]   wait_cnt;
	logic                sample;
	logic                low_half;
	logic                ack;
	logic [WB_DAT_W-1:0] rd_dat;

	assign sample = (wait_cnt == WAIT_LAST);
	assign low_half = (state == ST_LOW);

	// Halfword 2w then 2w+1
	assign flash_adr_o = {wb_i.adr[FLASH_ADR_W:2], low_half};

	// ----------------------------------------
	// Access sequencer
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state <= ST_IDLE;
			wait_cnt <= '0;
			ack <= 1'b0;
		end else begin
			ack <= 1'b0;
			case (state)
				ST_IDLE: begin
					wait_cnt <= '0;
					// Writes are acked and dropped, flash is read only here
					if (wb_i.cyc && wb_i.stb && !ack) begin
						if (wb_i.we)
							ack <= 1'b1;
						else
							state <= ST_HIGH;
					end
				end
				ST_HIGH: begin
					wait_cnt <= sample ? '0 : wait_cnt + 1'b1;
					if (sample)
						state <= ST_LOW;
				end
				default: begin
					wait_cnt <= sample ? '0 : wait_cnt + 1'b1;
					if (sample) begin
						state <= ST_IDLE;
						ack <= 1'b1;
					end
				end
			endcase
		end
	end

	// First halfword lands in the upper half
	always_ff @(posedge sys_clk) begin
		if (sample && state == ST_HIGH)
			rd_dat[WB_DAT_W-1 -: FLASH_DAT_W] <= flash_d_i;
		if (sample && low_half)
			rd_dat[FLASH_DAT_W-1:0] <= flash_d_i;
	end

	assign wb_o.dat = rd_dat;
	assign wb_o.ack = ack;

endmodule

// ==== hdl/reset_gen.sv ====
// Reset sequencer
`timescale 1ns/1ps

module reset_gen (
	input  logic sys_clk,
	input  logic hard_reset,
	output logic flash_rst_n_o,
	output logic sys_rst_o
);
	import csr_pkg::*;

	localparam int FLASH_CNT_W = $clog2(FLASH_RST_CYCLES + 1);
	localparam int SYS_CNT_W = $clog2(SYS_RST_CYCLES + 1);
	localparam logic [FLASH_CNT_W-1:0] FLASH_LAST = FLASH_CNT_W'(FLASH_RST_CYCLES);
	localparam logic [SYS_CNT_W-1:0] SYS_LAST = SYS_CNT_W'(SYS_RST_CYCLES);

	logic [FLASH_CNT_W-1:0] flash_cnt;
	logic [SYS_CNT_W-1:0]   sys_cnt;

	// Both count cycles with hard_reset low, then stick
	always_ff @(posedge sys_clk) begin
		if (hard_reset) begin
			flash_cnt <= '0;
			sys_cnt <= '0;
		end else begin
			if (flash_cnt != FLASH_LAST)
				flash_cnt <= flash_cnt + 1'b1;
			if (sys_cnt != SYS_LAST)
				sys_cnt <= sys_cnt + 1'b1;
		end
	end

	// Flash leaves reset first so it answers once the bus wakes up
	assign flash_rst_n_o = (flash_cnt == FLASH_LAST);
	assign sys_rst_o = (sys_cnt != SYS_LAST);

endmodule

// ==== hdl/soc_top.sv ====
// Reduced SoC core
`timescale 1ns/1ps

module soc_top (
	input  logic                             sys_clk,
	input  logic                             hard_reset,
	input  wb_pkg::wb_m2s_t                  wb_i,
	output wb_pkg::wb_s2m_t                  wb_o,
	output logic [wb_pkg::FLASH_ADR_W-1:0]   flash_adr_o,
	input  logic [wb_pkg::FLASH_DAT_W-1:0]   flash_d_i,
	output logic                             flash_rst_n_o,
	input  logic [csr_pkg::NUM_GPIO_IN-1:0]  gpio_i,
	output logic [csr_pkg::NUM_GPIO_OUT-1:0] gpio_o,
	output logic                             timer_irq_o
);
	import wb_pkg::*;
	import csr_pkg::*;

	logic                 sys_rst;
	wb_m2s_t              flash_m2s;
	wb_s2m_t              flash_s2m;
	wb_m2s_t              csrbrg_m2s;
	wb_s2m_t              csrbrg_s2m;
	csr_m2s_t             csr_bus;
	logic [CSR_DAT_W-1:0] csr_dr;

	// ----------------------------------------
	// Reset
	// ----------------------------------------
	reset_gen reset_gen0 (
		.sys_clk      (sys_clk),
		.hard_reset   (hard_reset),
		.flash_rst_n_o(flash_rst_n_o),
		.sys_rst_o    (sys_rst)
	);

	// ----------------------------------------
	// Bus fabric
	// ----------------------------------------
	wb_decoder wb_decoder0 (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst),
		.m_i      (wb_i),
		.m_o      (wb_o),
		.flash_o  (flash_m2s),
		.flash_i  (flash_s2m),
		.csr_o    (csrbrg_m2s),
		.csr_i    (csrbrg_s2m)
	);

	// Boot flash at 0x00000000
	norflash16 norflash0 (
		.sys_clk    (sys_clk),
		.sys_rst_i  (sys_rst),
		.wb_i       (flash_m2s),
		.wb_o       (flash_s2m),
		.flash_adr_o(flash_adr_o),
		.flash_d_i  (flash_d_i)
	);

	// CSR space at 0x80000000
	csr_bridge csr_bridge0 (
		.sys_clk  (sys_clk),
		.sys_rst_i(sys_rst),
		.wb_i     (csrbrg_m2s),
		.wb_o     (csrbrg_s2m),
		.csr_o    (csr_bus),
		.csr_dr_i (csr_dr)
	);

	// Single CSR slave, so no OR of read buses
	sysctl sysctl0 (
		.sys_clk    (sys_clk),
		.sys_rst_i  (sys_rst),
		.csr_i      (csr_bus),
		.csr_dr_o   (csr_dr),
		.gpio_i     (gpio_i),
		.gpio_o     (gpio_o),
		.timer_irq_o(timer_irq_o)
	);

endmodule

// ==== hdl/sysctl.sv ====
// System controller
`timescale 1ns/1ps

module sysctl (
	input  logic                             sys_clk,
	input  logic                             sys_rst_i,
	input  csr_pkg::csr_m2s_t                csr_i,
	output logic [csr_pkg::CSR_DAT_W-1:0]    csr_dr_o,
	input  logic [csr_pkg::NUM_GPIO_IN-1:0]  gpio_i,
	output logic [csr_pkg::NUM_GPIO_OUT-1:0] gpio_o,
	output logic                             timer_irq_o
);
	import csr_pkg::*;

	logic                    bank_sel;
	logic [CSR_REG_W-1:0]    reg_ofs;
	logic [NUM_GPIO_IN-1:0]  gpio_meta;
	logic [NUM_GPIO_IN-1:0]  gpio_sync;
	logic [NUM_GPIO_OUT-1:0] gpio_out;
	logic                    timer_en;
	logic                    timer_pending;
	logic [CSR_DAT_W-1:0]    timer_cmp;
	logic [CSR_DAT_W-1:0]    timer_cnt;

	assign bank_sel = (csr_i.a[CSR_ADR_W-1 -: CSR_BANK_W] == SYSCTL_BANK);
	assign reg_ofs = csr_i.a[CSR_REG_W-1:0];

	// Two-flop synchronizer on the buttons
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_i;
		gpio_sync <= gpio_meta;
	end

	// ----------------------------------------
	// Timer and register writes
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			gpio_out <= '0;
			timer_en <= 1'b0;
			timer_pending <= 1'b0;
			timer_cmp <= '0;
			timer_cnt <= '0;
		end else begin
			// Wrap on compare match and flag it
			if (timer_en) begin
				if (timer_cnt == timer_cmp) begin
					timer_pending <= 1'b1;
					timer_cnt <= '0;
				end else begin
					timer_cnt <= timer_cnt + 1'b1;
				end
			end
			// Bus write wins over the timer in the same cycle
			if (bank_sel && csr_i.we) begin
				case (reg_ofs)
					REG_GPIO_OUT: gpio_out <= csr_i.dw[NUM_GPIO_OUT-1:0];
					REG_TIMER_CTRL: begin
						timer_en <= csr_i.dw[0];
						if (csr_i.dw[1])
							timer_pending <= 1'b0;
					end
					REG_TIMER_CMP: timer_cmp <= csr_i.dw;
					REG_TIMER_CNT: timer_cnt <= csr_i.dw;
					default: ;
				endcase
			end
		end
	end

	// ----------------------------------------
	// Read mux, registered
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		csr_dr_o <= '0;
		if (bank_sel) begin
			case (reg_ofs)
				REG_GPIO_IN: csr_dr_o <= CSR_DAT_W'(gpio_sync);
				REG_GPIO_OUT: csr_dr_o <= CSR_DAT_W'(gpio_out);
				REG_TIMER_CTRL: csr_dr_o <= CSR_DAT_W'({timer_pending, timer_en});
				REG_TIMER_CMP: csr_dr_o <= timer_cmp;
				REG_TIMER_CNT: csr_dr_o <= timer_cnt;
				REG_SYSTEM_ID: csr_dr_o <= SYSTEM_ID;
				default: csr_dr_o <= '0;
			endcase
		end
	end

	assign gpio_o = gpio_out;
	// Level interrupt, held until software clears it
	assign timer_irq_o = timer_pending;

endmodule

// ==== hdl/wb_decoder.sv ====
// Wishbone region decoder
`timescale 1ns/1ps

module wb_decoder (
	input  logic            sys_clk,
	input  logic            sys_rst_i,
	input  wb_pkg::wb_m2s_t m_i,
	output wb_pkg::wb_s2m_t m_o,
	output wb_pkg::wb_m2s_t flash_o,
	input  wb_pkg::wb_s2m_t flash_i,
	output wb_pkg::wb_m2s_t csr_o,
	input  wb_pkg::wb_s2m_t csr_i
);
	import wb_pkg::*;

	logic [REGION_W-1:0] region;
	logic                hit_flash;
	logic                hit_csr;
	logic                unmapped_ack;

	assign region = m_i.adr[WB_ADR_W-1 -: REGION_W];
	assign hit_flash = (region == REGION_FLASH);
	assign hit_csr = (region == REGION_CSR);

	// Request side, only the selected slave sees stb
	always_comb begin
		flash_o = m_i;
		flash_o.stb = m_i.stb & hit_flash;
		csr_o = m_i;
		csr_o.stb = m_i.stb & hit_csr;
	end

	// ----------------------------------------
	// Default responder for free regions
	// ----------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i)
			unmapped_ack <= 1'b0;
		else
			unmapped_ack <= m_i.cyc & m_i.stb & ~hit_flash & ~hit_csr & ~unmapped_ack;
	end

	// Response side, no added latency for mapped slaves
	always_comb begin
		if (hit_flash) begin
			m_o = flash_i;
		end else if (hit_csr) begin
			m_o = csr_i;
		end else begin
			m_o.dat = '0;
			m_o.ack = unmapped_ack;
		end
	end

endmodule

// ==== hdl/wb_pkg.sv ====
// Wishbone bus definitions
package wb_pkg;

	// ----------------------------------------
	// Bus widths
	// ----------------------------------------
	localparam int WB_ADR_W = 32;
	localparam int WB_DAT_W = 32;
	localparam int WB_SEL_W = WB_DAT_W / 8;

	// Master to slave, classic cycles only
	typedef struct packed {
		logic [WB_ADR_W-1:0] adr;
		logic [WB_DAT_W-1:0] dat;
		logic [WB_SEL_W-1:0] sel;
		logic                we;
		logic                cyc;
		logic                stb;
	} wb_m2s_t;

	// Slave to master
	typedef struct packed {
		logic [WB_DAT_W-1:0] dat;
		logic                ack;
	} wb_s2m_t;

	// Region codes in address bits 31:29
	localparam int REGION_W = 3;
	localparam logic [REGION_W-1:0] REGION_FLASH = 3'b000;
	localparam logic [REGION_W-1:0] REGION_CSR = 3'b100;

	// Boot flash, halfword addressed
	localparam int FLASH_ADR_W = 24;
	localparam int FLASH_DAT_W = 16;
	localparam int FLASH_WAIT = 4;

endpackage

// ==== mini_soc.f ====
hdl/wb_pkg.sv
hdl/csr_pkg.sv
hdl/reset_gen.sv
hdl/wb_decoder.sv
hdl/norflash16.sv
hdl/csr_bridge.sv
hdl/sysctl.sv
hdl/soc_top.sv
test/soc_assert.sv
test/tb_soc.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the SoC core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ"
if ! verilator --binary --assert --top-module tb_soc -Mdir "$OBJ" -f mini_soc.f; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/Vtb_soc" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

echo "Simulation passed"
exit 0

// ==== test/soc_assert.sv ====
// Top-level bus and reset checks
`timescale 1ns/1ps

module soc_assert (
	input logic            sys_clk,
	input logic            hard_reset,
	input wb_pkg::wb_m2s_t req_i,
	input wb_pkg::wb_s2m_t rsp_i,
	input logic            flash_rst_n_i
);

	// ----------------------------------------
	// Wishbone classic handshake
	// ----------------------------------------
	ack_needs_request: assert property (
		@(posedge sys_clk) disable iff (hard_reset)
		rsp_i.ack |-> (req_i.cyc && req_i.stb)
	) else $error("ack seen without cyc and stb");

	// Single-cycle ack per access
	ack_one_cycle: assert property (
		@(posedge sys_clk) disable iff (hard_reset)
		rsp_i.ack |=> !rsp_i.ack
	) else $error("ack held for two cycles");

	// Flash reset only re-enters through hard_reset
	flash_rst_from_hard_reset: assert property (
		@(posedge sys_clk) disable iff (hard_reset)
		$fell(flash_rst_n_i) |-> $past(hard_reset)
	) else $error("flash_rst_n_o fell without hard_reset");

endmodule

bind soc_top soc_assert soc_assert0 (
	.sys_clk      (sys_clk),
	.hard_reset   (hard_reset),
	.req_i        (wb_i),
	.rsp_i        (wb_o),
	.flash_rst_n_i(flash_rst_n_o)
);

// ==== test/soc_patterns.txt ====
# op address data gpio_i, all hex; data is write data or expected read data
# W write, R read (data F = flash contents rule), I wait for the timer interrupt
R 00000000 F 0
R 00000004 F 0
R 00000010 F 0
R 00123458 F 0
R 01FFFFFC F 0
W 00000010 DEADBEEF 0
R 00000010 F 0
R 80001014 534F4331 0
W 80001004 00000003 5
R 80001004 00000003 5
R 80001000 00000005 5
W 80001004 00000002 2
R 80001000 00000002 2
W 8000100C 0000000A 2
W 80001008 00000001 2
I 00000000 00000000 2
R 80001008 00000003 2
W 80001008 00000002 2
R 80001008 00000000 2
R 20000000 00000000 0
R 40000000 00000000 0
R A0000000 00000000 0
R 80002014 00000000 0
R 80000014 00000000 0

// ==== test/tb_soc.sv ====
// SoC core testbench
`timescale 1ns/1ps

module tb_soc;
	import wb_pkg::*;
	import csr_pkg::*;

	localparam string PATTERN_FILE = "test/soc_patterns.txt";
	localparam int CYCLES_PER_LINE = 64;
	localparam int MAX_GAP = 3;

	logic                    sys_clk;
	logic                    hard_reset;
	wb_m2s_t                 wb_m2s;
	wb_s2m_t                 wb_s2m;
	logic [FLASH_ADR_W-1:0]  flash_adr;
	logic [FLASH_DAT_W-1:0]  flash_d;
	logic                    flash_rst_n;
	logic [NUM_GPIO_IN-1:0]  gpio_in;
	logic [NUM_GPIO_OUT-1:0] gpio_out;
	logic                    timer_irq;
	int                      cycle_cnt;
	int                      cycle_limit;
	bit                      verdict_done;

	soc_top dut0 (
		.sys_clk      (sys_clk),
		.hard_reset   (hard_reset),
		.wb_i         (wb_m2s),
		.wb_o         (wb_s2m),
		.flash_adr_o  (flash_adr),
		.flash_d_i    (flash_d),
		.flash_rst_n_o(flash_rst_n),
		.gpio_i       (gpio_in),
		.gpio_o       (gpio_out),
		.timer_irq_o  (timer_irq)
	);

	// 40 ns period
	always #20 sys_clk = ~sys_clk;

	// ----------------------------------------
	// Flash model and address helpers
	// ----------------------------------------
	function automatic logic [FLASH_DAT_W-1:0] flash_half(input logic [FLASH_ADR_W-1:0] h);
		return h[FLASH_DAT_W-1:0] ^ 16'h5A5A;
	endfunction

	assign flash_d = flash_half(flash_adr);

	// Halfwords 2w and 2w+1, first one on top
	function automatic logic [WB_DAT_W-1:0] flash_word(input logic [WB_ADR_W-1:0] adr);
		logic [WB_ADR_W-1:0] w;
		w = adr >> 2;
		return {flash_half(FLASH_ADR_W'(2 * w)), flash_half(FLASH_ADR_W'(2 * w + 1))};
	endfunction

	function automatic logic [WB_ADR_W-1:0] csr_addr(input logic [CSR_BANK_W-1:0] bank,
			input logic [CSR_REG_W-1:0] ofs);
		return {REGION_CSR, {(WB_ADR_W - REGION_W - CSR_ADR_W - 2){1'b0}}, bank, ofs, 2'b00};
	endfunction

	// Skips blank lines and # comments
	function automatic bit is_data_line(input string s);
		return (s.len() > 1) && (s.getc(0) != "#");
	endfunction

	function automatic int count_patterns();
		int fd;
		int n;
		string line;
		n = 0;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0)
			return 0;
		while ($fgets(line, fd) > 0) begin
			if (is_data_line(line))
				n++;
		end
		$fclose(fd);
		return n;
	endfunction

	// ----------------------------------------
	// Failure and compare tasks
	// ----------------------------------------
	task automatic report_failure();
		verdict_done = 1'b1;
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		report_failure();
	endtask

	task automatic check_word(input string name, input wb_s2m_t rsp,
			input logic [WB_DAT_W-1:0] exp);
		if (rsp.dat !== exp) begin
			$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, rsp.dat, exp);
			report_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
			report_failure();
		end
	endtask

	task automatic check_gpio_out(input logic [NUM_GPIO_OUT-1:0] exp);
		int i;
		for (i = 0; i < NUM_GPIO_OUT; i++)
			check_bit($sformatf("gpio_o[%0d]", i), gpio_out[i], exp[i]);
	endtask

	// ----------------------------------------
	// Bus master
	// ----------------------------------------
	task automatic drive_request(input logic we, input logic [WB_ADR_W-1:0] adr,
			input logic [WB_DAT_W-1:0] dat);
		wb_m2s.adr = adr;
		wb_m2s.dat = dat;
		wb_m2s.sel = '1;
		wb_m2s.we = we;
		wb_m2s.cyc = 1'b1;
		wb_m2s.stb = 1'b1;
	endtask

	// Held through the ack cycle, dropped in the next one
	task automatic bus_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
			input logic [WB_DAT_W-1:0] dat, output wb_s2m_t rsp);
		drive_request(we, adr, dat);
		do begin
			@(negedge sys_clk);
		end while (!wb_s2m.ack);
		rsp = wb_s2m;
		@(negedge sys_clk);
		wb_m2s = '0;
	endtask

	task automatic check_write_effects(input logic [WB_ADR_W-1:0] adr,
			input logic [WB_DAT_W-1:0] dat);
		if (adr == csr_addr(SYSCTL_BANK, REG_GPIO_OUT))
			check_gpio_out(dat[NUM_GPIO_OUT-1:0]);
		// Clear with enable off, line must be low
		if (adr == csr_addr(SYSCTL_BANK, REG_TIMER_CTRL) && dat[1:0] == 2'b10)
			check_bit("timer_irq_o", timer_irq, 1'b0);
	endtask

	// Read issued together with the release
	task automatic check_reset_release();
		int k;
		wb_s2m_t rsp;
		k = 0;
		hard_reset = 1'b0;
		drive_request(1'b0, csr_addr(SYSCTL_BANK, REG_SYSTEM_ID), '0);
		do begin
			@(negedge sys_clk);
			k++;
			check_bit("flash_rst_n_o", flash_rst_n, k >= FLASH_RST_CYCLES);
			if (k < SYS_RST_CYCLES) begin
				check_bit("wb_o.ack", wb_s2m.ack, 1'b0);
				check_bit("timer_irq_o", timer_irq, 1'b0);
				check_gpio_out('0);
			end
		end while (!wb_s2m.ack);
		rsp = wb_s2m;
		check_word("wb_o.dat (system id)", rsp, SYSTEM_ID);
		@(negedge sys_clk);
		wb_m2s = '0;
	endtask

	// ----------------------------------------
	// Pattern player
	// ----------------------------------------
	task automatic play_patterns();
		int fd;
		string line;
		string op;
		string exp_str;
		logic [WB_ADR_W-1:0] adr;
		logic [WB_DAT_W-1:0] dat;
		logic [NUM_GPIO_IN-1:0] gpio_val;
		wb_s2m_t rsp;
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0)
			abort_run("Cannot open the pattern file");
		while ($fgets(line, fd) > 0) begin
			if (!is_data_line(line))
				continue;
			if ($sscanf(line, "%s %h %s %h", op, adr, exp_str, gpio_val) != 4)
				abort_run({"Malformed pattern line: ", line});
			// F selects the flash contents rule
			if (exp_str == "F")
				dat = flash_word(adr);
			else
				void'($sscanf(exp_str, "%h", dat));
			gpio_in = gpio_val;
			repeat ($urandom_range(MAX_GAP)) @(negedge sys_clk);
			if (op == "W") begin
				bus_cycle(1'b1, adr, dat, rsp);
				check_write_effects(adr, dat);
			end else if (op == "R") begin
				bus_cycle(1'b0, adr, '0, rsp);
				check_word($sformatf("wb_o.dat @%h", adr), rsp, dat);
			end else if (op == "I") begin
				do begin
					@(negedge sys_clk);
				end while (!timer_irq);
			end else begin
				abort_run({"Unknown operation in pattern line: ", line});
			end
		end
		$fclose(fd);
	endtask

	// Watchdog
	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
			abort_run($sformatf("Timeout, no response after %0d cycles", cycle_cnt));
	end

	initial begin
		sys_clk = 1'b0;
		hard_reset = 1'b1;
		wb_m2s = '0;
		gpio_in = '0;
		void'($urandom(53));
		cycle_limit = count_patterns() * CYCLES_PER_LINE + SYS_RST_CYCLES;
		if (cycle_limit == SYS_RST_CYCLES)
			abort_run("Pattern file missing or empty");
		repeat (4) @(negedge sys_clk);
		check_reset_release();
		play_patterns();
		verdict_done = 1'b1;
		$display("Everything OK");
		$finish;
	end

	// Run ended with no verdict
	final begin
		if (!verdict_done)
			$display("Something failed");
	end

endmodule
